// File: common/mulPkg.sv
// Multiply unit shared definitions
`default_nettype none

package mulPkg;

	// pipeline slots, also the request credits upstream starts with
	localparam int PIPE_DEPTH = 3;
	// most result credits the consumer may hold out at once
	localparam int RES_CREDITS = 4;
	localparam int CREDIT_WIDTH = 3;

	// fast divide range, divisor below 2^6 and dividend below 2^30
	localparam int DIVISOR_BITS = 6;
	localparam int DIVIDEND_BITS = 30;
	// reciprocal scale, a divisor d with s = ceil(log2 d) uses 2^(30+s)/d
	localparam int DIV_BASE_SHIFT = 30;

	typedef enum logic [1:0] {
		MUL_S = 2'd0,
		MUL_U = 2'd1,
		MAC_S = 2'd2,
		DIV_U = 2'd3
	} mulOpE;

	typedef struct packed {
		mulOpE op;
		logic [3:0] tag;
		// multiplicand or dividend
		logic [31:0] srcA;
		// multiplier or divisor
		logic [31:0] srcB;
		// only read by MAC_S
		logic [63:0] addend;
	} mulReqT;

	typedef struct packed {
		logic [3:0] tag;
		logic [63:0] value;
		// divide outside the fast range
		logic err;
	} mulResT;

	// stage 1 to stage 2 record
	typedef struct packed {
		logic [31:0] ppLL;
		logic [31:0] ppLH;
		logic [31:0] ppHL;
		logic [31:0] ppHH;
		logic [63:0] addend;
		logic [3:0] tag;
		mulOpE op;
		// zero means unit multiplier, no shift
		logic [2:0] divShift;
		logic err;
	} mulStageT;

endpackage

`default_nettype wire

// File: mulUnit/mulIssueCtrl.sv
// Multiply unit issue control
`timescale 1ns/1ps
`default_nettype none

module mulIssueCtrl (
	input wire clock,
	input wire rstN,
	input wire reqValid,
	input wire resCredit,
	output logic advance1,
	output logic advance2,
	output logic advance3,
	output logic resValid,
	output logic reqCredit
);
	import mulPkg::*;

	// bit 0 is stage 1, bit 2 is the output stage
	logic [PIPE_DEPTH-1:0] stageValid;
	// result credits granted by the consumer and not yet spent
	logic [CREDIT_WIDTH-1:0] creditCnt;
	logic creditAvail;

	assign creditAvail = (creditCnt != '0);

	// stage 3 drains only with a credit in hand
	assign resValid = stageValid[2] && creditAvail;
	// each result leaving frees one slot for upstream
	assign reqCredit = resValid;

	// a stage loads when its successor is empty or draining this cycle
	assign advance3 = stageValid[1] && (!stageValid[2] || resValid);
	assign advance2 = stageValid[0] && (!stageValid[1] || advance3);
	assign advance1 = reqValid && (!stageValid[0] || advance2);

	always_ff @(posedge clock) begin
		if (!rstN) begin
			stageValid <= '0;
		end else begin
			stageValid[0] <= advance1 || (stageValid[0] && !advance2);
			stageValid[1] <= advance2 || (stageValid[1] && !advance3);
			stageValid[2] <= advance3 || (stageValid[2] && !resValid);
		end
	end

	// grant and spend in the same cycle cancel out
	always_ff @(posedge clock) begin
		if (!rstN) begin
			creditCnt <= '0;
		end else if (resCredit && !resValid) begin
			creditCnt <= creditCnt + CREDIT_WIDTH'(1);
		end else if (!resCredit && resValid) begin
			creditCnt <= creditCnt - CREDIT_WIDTH'(1);
		end
	end

endmodule

`default_nettype wire

// File: mulUnit/mulReciprocalRom.sv
// Divisor reciprocal table
`timescale 1ns/1ps
`default_nettype none

module mulReciprocalRom (
	input wire [mulPkg::DIVISOR_BITS-1:0] divisor,
	output logic [31:0] recip,
	output logic [2:0] shift,
	output logic exact
);
	import mulPkg::*;

	logic [31:0] recipRom [2**DIVISOR_BITS];
	logic [2:0] shiftRom [2**DIVISOR_BITS];

	// table filled at elaboration, one entry per divisor
	for (genvar d = 0; d < 2**DIVISOR_BITS; d++) begin : romEntry
		if (d < 2) begin : noEntry
			// 0 and 1 have no reciprocal here
			assign recipRom[d] = '0;
			assign shiftRom[d] = '0;
		end else begin : fastEntry
			// rounded up so the truncated quotient is exact below 2^30
			assign recipRom[d] = 32'(((64'd1 << (DIV_BASE_SHIFT + $clog2(d)))
				+ 64'(d) - 64'd1) / 64'(d));
			// s = ceil(log2 d), at most 6
			assign shiftRom[d] = 3'($clog2(d));
		end
	end

	// the error bound x*(m*d - 2^(30+s)) < 2^(30+s) holds for every
	// dividend under 2^30, so all divisors from 2 up qualify
	always_comb begin
		recip = recipRom[divisor];
		shift = shiftRom[divisor];
		exact = (divisor > DIVISOR_BITS'(1));
	end

endmodule

`default_nettype wire

// File: mulUnit/mulPartialProducts.sv
// Multiply stage 1 partial products
`timescale 1ns/1ps
`default_nettype none

module mulPartialProducts (
	input wire clock,
	input wire rstN,
	input wire advance1,
	input wire mulPkg::mulReqT req,
	output mulPkg::mulStageT stage
);
	import mulPkg::*;

	logic [31:0] romRecip;
	logic [2:0] romShift;
	logic romExact;

	logic isDiv;
	logic isSigned;
	logic divUnit;
	logic divOk;
	logic divErr;
	logic [31:0] opA;
	logic [31:0] opB;

	// 17 bits so each half can carry its own sign
	logic signed [16:0] aLo;
	logic signed [16:0] aHi;
	logic signed [16:0] bLo;
	logic signed [16:0] bHi;
	logic signed [33:0] prodLL;
	logic signed [33:0] prodLH;
	logic signed [33:0] prodHL;
	logic signed [33:0] prodHH;

	mulStageT stageNext;

	mulReciprocalRom mulReciprocalRom_i (
		.divisor(req.srcB[DIVISOR_BITS-1:0]),
		.recip(romRecip),
		.shift(romShift),
		.exact(romExact)
	);

	// operand conditioning
	always_comb begin
		isDiv = (req.op == DIV_U);
		isSigned = (req.op == MUL_S) || (req.op == MAC_S);
		divUnit = (req.srcB == 32'd1);
		divOk = (req.srcB[31:DIVISOR_BITS] == '0) && (req.srcA[31:DIVIDEND_BITS] == '0)
			&& (romExact || divUnit);
		divErr = isDiv && !divOk;

		// an out of range divide multiplies zero by zero
		opA = divErr ? '0 : req.srcA;
		if (!isDiv) begin
			opB = req.srcB;
		end else if (divErr) begin
			opB = '0;
		end else begin
			opB = divUnit ? 32'd1 : romRecip;
		end
	end

	// upper halves are sign extended only for signed ops
	always_comb begin
		aLo = {1'b0, opA[15:0]};
		aHi = {isSigned && opA[31], opA[31:16]};
		bLo = {1'b0, opB[15:0]};
		bHi = {isSigned && opB[31], opB[31:16]};

		prodLL = aLo * bLo;
		prodLH = aLo * bHi;
		prodHL = aHi * bLo;
		prodHH = aHi * bHi;

		stageNext.ppLL = prodLL[31:0];
		stageNext.ppLH = prodLH[31:0];
		stageNext.ppHL = prodHL[31:0];
		stageNext.ppHH = prodHH[31:0];
		stageNext.addend = req.addend;
		stageNext.tag = req.tag;
		stageNext.op = req.op;
		stageNext.divShift = (isDiv && !divUnit && !divErr) ? romShift : '0;
		stageNext.err = divErr;
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			stage.err <= 1'b0;
			stage.divShift <= '0;
		end else if (advance1) begin
			stage <= stageNext;
		end
	end

endmodule

`default_nettype wire

// File: mulUnit/mulCompressor.sv
// Multiply stage 2 and 3 summation
`timescale 1ns/1ps
`default_nettype none

module mulCompressor (
	input wire clock,
	input wire rstN,
	input wire advance2,
	input wire advance3,
	input wire mulPkg::mulStageT stage,
	output mulPkg::mulResT res
);
	import mulPkg::*;

	// stage 2 record, cross products already folded
	typedef struct packed {
		logic [32:0] crossSum;
		logic [31:0] ppLL;
		logic [31:0] ppHH;
		logic [63:0] addend;
		logic [3:0] tag;
		mulOpE op;
		logic [2:0] divShift;
		logic err;
	} sumStageT;

	sumStageT sum2;
	sumStageT sum2Next;
	logic signed1;
	logic signed2;
	logic [63:0] crossWide;
	logic [63:0] product;
	logic [63:0] quotient;
	logic [5:0] shiftAmt;
	mulResT resNext;

	// stage 2 cross product sum, 33 bits holds either signedness
	always_comb begin
		signed1 = (stage.op == MUL_S) || (stage.op == MAC_S);
		sum2Next.crossSum = {signed1 && stage.ppLH[31], stage.ppLH}
			+ {signed1 && stage.ppHL[31], stage.ppHL};
		sum2Next.ppLL = stage.ppLL;
		sum2Next.ppHH = stage.ppHH;
		sum2Next.addend = stage.addend;
		sum2Next.tag = stage.tag;
		sum2Next.op = stage.op;
		sum2Next.divShift = stage.divShift;
		sum2Next.err = stage.err;
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			sum2.err <= 1'b0;
			sum2.divShift <= '0;
		end else if (advance2) begin
			sum2 <= sum2Next;
		end
	end

	// stage 3 full product and result select
	always_comb begin
		signed2 = (sum2.op == MUL_S) || (sum2.op == MAC_S);
		crossWide = {{15{signed2 && sum2.crossSum[32]}}, sum2.crossSum, 16'd0};
		// high word wraps mod 2^64 the same way for both signs
		product = {sum2.ppHH, 32'd0} + crossWide + {32'd0, sum2.ppLL};

		shiftAmt = 6'(DIV_BASE_SHIFT) + 6'(sum2.divShift);
		// divShift of zero marks a divide by one
		quotient = (sum2.divShift == '0) ? product : (product >> shiftAmt);

		resNext.tag = sum2.tag;
		resNext.err = sum2.err;
		case (sum2.op)
			MAC_S: resNext.value = product + sum2.addend;
			DIV_U: resNext.value = {32'd0, quotient[31:0]};
			default: resNext.value = product;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			res.err <= 1'b0;
		end else if (advance3) begin
			res <= resNext;
		end
	end

endmodule

`default_nettype wire

// File: source/mulTop.sv
// Multiply unit top level
`timescale 1ns/1ps
`default_nettype none

module mulTop (
	input wire clock,
	input wire rstN,
	input wire reqValid,
	input wire mulPkg::mulReqT req,
	input wire resCredit,
	output logic reqCredit,
	output logic resValid,
	output mulPkg::mulResT res
);
	import mulPkg::*;

	logic advance1;
	logic advance2;
	logic advance3;

	// stage 1 register contents
	mulStageT stage1;

	mulIssueCtrl mulIssueCtrl_i (
		.clock(clock),
		.rstN(rstN),
		.reqValid(reqValid),
		.resCredit(resCredit),
		.advance1(advance1),
		.advance2(advance2),
		.advance3(advance3),
		.resValid(resValid),
		.reqCredit(reqCredit)
	);

	mulPartialProducts mulPartialProducts_i (
		.clock(clock),
		.rstN(rstN),
		.advance1(advance1),
		.req(req),
		.stage(stage1)
	);

	mulCompressor mulCompressor_i (
		.clock(clock),
		.rstN(rstN),
		.advance2(advance2),
		.advance3(advance3),
		.stage(stage1),
		.res(res)
	);

endmodule

`default_nettype wire

// File: test/mulTb_sva.sv
// Issue control credit assertions
`timescale 1ns/1ps
`default_nettype none

module creditChecks (
	input wire clock,
	input wire rstN,
	input wire resValid,
	input wire reqCredit,
	input wire [mulPkg::CREDIT_WIDTH-1:0] creditCnt,
	input wire [mulPkg::PIPE_DEPTH-1:0] stageValid
);
	import mulPkg::*;

	// consumer never holds out more than the limit
	creditBound: assert property (@(posedge clock) disable iff (!rstN)
		creditCnt <= CREDIT_WIDTH'(RES_CREDITS))
		else $error("result credit counter at %0d, above the limit", creditCnt);

	noSendWithoutCredit: assert property (@(posedge clock) disable iff (!rstN)
		resValid |-> (creditCnt != '0))
		else $error("result sent with no result credit held");

	// every result leaving frees a request slot
	slotReturned: assert property (@(posedge clock) disable iff (!rstN)
		resValid == reqCredit)
		else $error("result valid and request credit out of step");

	resetClears: assert property (@(posedge clock)
		!rstN |=> (stageValid == '0 && !resValid))
		else $error("stage valid bits not cleared by reset");

endmodule

bind mulIssueCtrl creditChecks creditChecks_i (
	.clock(clock),
	.rstN(rstN),
	.resValid(resValid),
	.reqCredit(reqCredit),
	.creditCnt(creditCnt),
	.stageValid(stageValid)
);

`default_nettype wire

// File: test/mulTb.sv
// Multiply unit testbench
`timescale 1ns/1ps
`default_nettype none

module mulTb;
	import mulPkg::*;

	localparam int MUL_COUNT = 24;
	localparam int MAC_COUNT = 16;
	localparam int DIV_COUNT = 20;
	localparam int EDGE_COUNT = 7;
	localparam int BURST_COUNT = 7;
	localparam int TOTAL_REQS = 1 + MUL_COUNT + MAC_COUNT + DIV_COUNT + EDGE_COUNT
		+ BURST_COUNT;
	// about four cycles per request, plus reset and the stall windows
	localparam int CYCLE_LIMIT = 4 * TOTAL_REQS + 200;

	// divide corner cases, dividend then divisor
	localparam logic [31:0] EDGE_A [EDGE_COUNT] = '{
		32'h3fff_ffff, 32'h3fff_ffff, 32'h3fff_ffff, 32'd12345,
		32'd100, 32'h4000_0000, 32'd9
	};
	localparam logic [31:0] EDGE_B [EDGE_COUNT] = '{
		32'd63, 32'd1, 32'd3, 32'd0, 32'd64, 32'd7, 32'hffff_ffc1
	};

	logic clock = 1'b0;
	logic rstN = 1'b0;
	logic reqValid = 1'b0;
	mulReqT req = '0;
	logic resCredit = 1'b0;
	logic reqCredit;
	logic resValid;
	mulResT res;

	logic [31:0] lfsrState = 32'h7e28_009f;
	logic [3:0] nextTag = 4'd0;
	logic autoCredit = 1'b1;
	int cycleCount = 0;
	int upCredits = PIPE_DEPTH;
	int creditsGiven = 0;
	int creditsReturned = 0;
	int creditsSent = 0;
	int resultCount = 0;
	int errorCount = 0;
	int reqSeenCycle = 0;
	int resSeenCycle = 0;
	mulResT expQ [$];
	mulResT expected;

	mulTop mulTop_i (
		.clock(clock),
		.rstN(rstN),
		.reqValid(reqValid),
		.req(req),
		.resCredit(resCredit),
		.reqCredit(reqCredit),
		.resValid(resValid),
		.res(res)
	);

	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] randBits(input int count);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrNext(lfsrState);
			val = {val[30:0], lfsrState[0]};
		end
		return val;
	endfunction

	function automatic mulReqT makeReq(input mulOpE op, input logic [31:0] a,
		input logic [31:0] b, input logic [63:0] addend);
		mulReqT r;
		r.op = op;
		r.tag = nextTag;
		r.srcA = a;
		r.srcB = b;
		r.addend = addend;
		nextTag = nextTag + 4'd1;
		return r;
	endfunction

	// expected result straight from the opcode definitions
	function automatic mulResT expectedResult(input mulReqT r);
		mulResT e;
		logic [63:0] sa;
		logic [63:0] sb;
		logic [63:0] ua;
		logic [63:0] ub;
		sa = {{32{r.srcA[31]}}, r.srcA};
		sb = {{32{r.srcB[31]}}, r.srcB};
		ua = {32'd0, r.srcA};
		ub = {32'd0, r.srcB};
		e.tag = r.tag;
		e.err = 1'b0;
		case (r.op)
			MUL_S: e.value = sa * sb;
			MUL_U: e.value = ua * ub;
			MAC_S: e.value = sa * sb + r.addend;
			default: begin
				if (r.srcB == 32'd0 || r.srcB > 32'd63 || r.srcA >= 32'h4000_0000) begin
					e.value = '0;
					e.err = 1'b1;
				end else begin
					e.value = ua / ub;
				end
			end
		endcase
		return e;
	endfunction

	task automatic checkValue(input mulResT want, input mulResT got);
		if (got.value !== want.value) begin
			$display("[FAIL] t=%0t res.value tag %0d expected %h actual %h",
				$time, want.tag, want.value, got.value);
			errorCount++;
		end
	endtask

	task automatic checkTag(input mulResT want, input mulResT got);
		if (got.tag !== want.tag) begin
			$display("[FAIL] t=%0t res.tag expected %0d actual %0d", $time, want.tag, got.tag);
			errorCount++;
		end
		if (got.err !== want.err) begin
			$display("[FAIL] t=%0t res.err tag %0d expected %b actual %b",
				$time, want.tag, want.err, got.err);
			errorCount++;
		end
	endtask

	// scoreboard, sampled mid cycle while every output is settled
	always @(negedge clock) begin
		if (rstN) begin
			if (reqValid) begin
				reqSeenCycle = cycleCount;
			end
			if (reqCredit) begin
				upCredits++;
			end
			if (resValid !== reqCredit) begin
				$display("result valid and request credit disagree at %0t", $time);
				errorCount++;
			end
			if (resValid) begin
				resSeenCycle = cycleCount;
				if (expQ.size() == 0) begin
					$display("result with tag %0d arrived with no request outstanding", res.tag);
					errorCount++;
				end else begin
					expected = expQ.pop_front();
					checkValue(expected, res);
					checkTag(expected, res);
				end
				resultCount++;
				if (autoCredit) begin
					creditsReturned++;
				end
			end
		end
	end

	// consumer hands back one result credit per cycle while any is owed
	always @(posedge clock) begin
		if (creditsGiven + creditsReturned > creditsSent) begin
			resCredit <= 1'b1;
			creditsSent++;
		end else begin
			resCredit <= 1'b0;
		end
	end

	task automatic grantCredits(input int count);
		@(negedge clock);
		creditsGiven += count;
	endtask

	task automatic sendReq(input mulReqT r);
		@(posedge clock);
		while (upCredits == 0) begin
			reqValid <= 1'b0;
			@(posedge clock);
		end
		reqValid <= 1'b1;
		req <= r;
		upCredits--;
		expQ.push_back(expectedResult(r));
	endtask

	task automatic endBurst();
		@(posedge clock);
		reqValid <= 1'b0;
	endtask

	task automatic waitResults(input int target);
		@(posedge clock);
		while (resultCount < target) begin
			@(posedge clock);
		end
	endtask

	task automatic reportTest(input string name, input int e0, input int r0);
		$display("test %-12s results %0d errors %0d", name, resultCount - r0, errorCount - e0);
	endtask

	task automatic runLatency();
		int e0;
		int r0;
		int latency;
		e0 = errorCount;
		r0 = resultCount;
		grantCredits(RES_CREDITS);
		sendReq(makeReq(MUL_U, randBits(32), randBits(32), 64'd0));
		endBurst();
		waitResults(r0 + 1);
		latency = resSeenCycle - reqSeenCycle;
		if (latency != 3) begin
			$display("[FAIL] t=%0t resValid latency expected 3 actual %0d", $time, latency);
			errorCount++;
		end
		reportTest("latency", e0, r0);
	endtask

	task automatic runMultiply();
		int e0;
		int r0;
		logic [31:0] a;
		logic [31:0] b;
		mulOpE op;
		e0 = errorCount;
		r0 = resultCount;
		for (int i = 0; i < MUL_COUNT; i++) begin
			op = (randBits(1) == 32'd1) ? MUL_U : MUL_S;
			a = randBits(32);
			b = randBits(32);
			sendReq(makeReq(op, a, b, 64'd0));
		end
		endBurst();
		waitResults(r0 + MUL_COUNT);
		reportTest("multiply", e0, r0);
	endtask

	task automatic runMac();
		int e0;
		int r0;
		logic [31:0] a;
		logic [31:0] b;
		logic [63:0] addend;
		e0 = errorCount;
		r0 = resultCount;
		for (int i = 0; i < MAC_COUNT; i++) begin
			a = randBits(32);
			b = randBits(32);
			addend[63:32] = randBits(32);
			addend[31:0] = randBits(32);
			sendReq(makeReq(MAC_S, a, b, addend));
		end
		endBurst();
		waitResults(r0 + MAC_COUNT);
		reportTest("accumulate", e0, r0);
	endtask

	task automatic runDivide();
		int e0;
		int r0;
		logic [31:0] dividend;
		logic [31:0] divisor;
		e0 = errorCount;
		r0 = resultCount;
		for (int i = 0; i < DIV_COUNT; i++) begin
			divisor = (randBits(6) % 32'd63) + 32'd1;
			dividend = randBits(30);
			sendReq(makeReq(DIV_U, dividend, divisor, 64'd0));
		end
		for (int i = 0; i < EDGE_COUNT; i++) begin
			sendReq(makeReq(DIV_U, EDGE_A[i], EDGE_B[i], 64'd0));
		end
		endBurst();
		waitResults(r0 + DIV_COUNT + EDGE_COUNT);
		reportTest("divide", e0, r0);
	endtask

	task automatic runBackPressure();
		int e0;
		int r0;
		e0 = errorCount;
		r0 = resultCount;
		// the consumer keeps what it gets, so only its held credits drain
		autoCredit = 1'b0;
		for (int i = 0; i < BURST_COUNT; i++) begin
			sendReq(makeReq(MUL_S, randBits(32), randBits(32), 64'd0));
		end
		endBurst();
		waitResults(r0 + RES_CREDITS);
		repeat (8) @(posedge clock);
		if (resultCount != r0 + RES_CREDITS || expQ.size() != PIPE_DEPTH) begin
			$display("results kept coming or the pipe did not fill while credits were held");
			errorCount++;
		end
		grantCredits(2);
		waitResults(r0 + RES_CREDITS + 2);
		repeat (6) @(posedge clock);
		if (resultCount != r0 + RES_CREDITS + 2) begin
			$display("a burst of results went beyond the two credits given");
			errorCount++;
		end
		grantCredits(1);
		waitResults(r0 + BURST_COUNT);
		reportTest("backpressure", e0, r0);
	endtask

	initial begin
		repeat (2) @(posedge clock);
		rstN <= 1'b1;
		runLatency();
		runMultiply();
		runMac();
		runDivide();
		runBackPressure();
		repeat (4) @(posedge clock);
		if (expQ.size() != 0) begin
			$display("%0d expected results never arrived", expQ.size());
			errorCount++;
		end
		$display("total results %0d of %0d, errors %0d", resultCount, TOTAL_REQS, errorCount);
		if (errorCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		while (cycleCount < CYCLE_LIMIT) begin
			@(negedge clock);
		end
		$display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
common/mulPkg.sv
mulUnit/mulIssueCtrl.sv
mulUnit/mulReciprocalRom.sv
mulUnit/mulPartialProducts.sv
mulUnit/mulCompressor.sv
source/mulTop.sv
test/mulTb_sva.sv
test/mulTb.sv

// File: Makefile
# Verilator build and run for the multiply unit

SOURCES := $(shell cat list.f)

.PHONY: run clean

run: obj_dir/VmulTb
	./obj_dir/VmulTb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

# rebuilt only when a source or the file list changes
obj_dir/VmulTb: list.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module mulTb -Mdir obj_dir -f list.f

clean:
	rm -rf obj_dir sim.log
